//--- cpu6809_top.f
+incdir+src
src/cpu6809_pkg.sv
src/alu8.sv
src/fetch_sequencer.sv
src/exec_unit.sv
src/pc_branch.sv
src/cpu6809_top.sv
sim/tb_cpu6809.sv

//--- run.sh
#!/bin/sh
# Build and run the accumulator core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module tb_cpu6809 \
  -f cpu6809_top.f -o tb_cpu6809
out="$(./obj_dir/tb_cpu6809)"
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF '** PASS **'; then
  exit 0
fi
exit 1

//--- sim/tb_cpu6809.sv
// ----------------------------------------------------------
// Testbench for the 8-bit accumulator core
// 64 KB memory model holding a random program from a fixed seed
// Instruction-level reference model with expected fetch trace
// Per-cycle address and register checks, watchdog
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "cpu6809_cfg.svh"

module tb_cpu6809;

  localparam int          SEED         = 78;
  localparam int          NUM_INSTR    = 200;
  localparam int          RESET_CYCLES = 16;
  localparam logic [15:0] LOAD_ADDR    = 16'h1000;

  // Inherent columns NEG COM LSR ROR ASR ASL ROL DEC INC TST CLR
  localparam logic [43:0] INH_COLS = {4'h0, 4'h3, 4'h4, 4'h6, 4'h7, 4'h8,
                                      4'h9, 4'hA, 4'hC, 4'hD, 4'hF};
  // Immediate columns SUB CMP SBC AND BIT LD EOR ADC OR ADD
  localparam logic [39:0] IMM_COLS = {4'h0, 4'h1, 4'h2, 4'h4, 4'h5,
                                      4'h6, 4'h8, 4'h9, 4'hA, 4'hB};

  logic        clk;
  logic        reset_b;
  logic [7:0]  din;
  logic [15:0] addr;
  logic [7:0]  acc_a;
  logic [7:0]  acc_b;
  logic [7:0]  cc_reg;

  // Byte-wide memory, read combinationally
  logic [7:0]  mem [0:65535];

  // ----------------------------------------------------------
  // Reference model state and expected trace
  // ----------------------------------------------------------
  logic [7:0]  m_a;
  logic [7:0]  m_b;
  logic [7:0]  m_cc;
  logic [15:0] m_pc;
  logic [15:0] gen_pc;
  // Address of the closing BRA to itself
  logic [15:0] loop_addr;
  int          prog_bytes;
  logic        gen_done;
  // One entry per fetch cycle from the first opcode on
  logic [15:0] exp_addr [$];
  // Register checkpoints, indexed by fetch cycle
  int          chk_cycle [$];
  logic [7:0]  chk_a [$];
  logic [7:0]  chk_b [$];
  logic [7:0]  chk_cc [$];

  int          err_reset;
  int          err_vector;
  int          err_fetch;
  int          err_regs;
  int          err_final;
  int          tests_passed;
  int          tests_failed;
  int          c;
  int          chk_idx;
  int          i;
  logic        diverged;

  assign din = mem[addr];

  cpu6809_top uut (
    .clk     (clk),
    .reset_b (reset_b),
    .din     (din),
    .addr    (addr),
    .acc_a   (acc_a),
    .acc_b   (acc_b),
    .cc_reg  (cc_reg)
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
    $display("** Error at time %0t: %s expected 0x%0h, got 0x%0h",
             $time, name, expected, actual);
  endtask

  task automatic finish_test(input string name, input int errors);
    if (errors == 0) begin
      $display("Test %s: passed", name);
      tests_passed++;
    end else begin
      $display("Test %s: failed with %0d errors", name, errors);
      tests_failed++;
    end
  endtask

  // Vector address on the bus, registers at their reset values
  task automatic check_reset_values();
    if (addr !== `RESET_VECTOR) begin
      report_mismatch("addr", `RESET_VECTOR, addr);
      err_reset++;
    end
    if (acc_a !== 8'h00) begin
      report_mismatch("acc_a", 16'h0000, {8'h00, acc_a});
      err_reset++;
    end
    if (acc_b !== 8'h00) begin
      report_mismatch("acc_b", 16'h0000, {8'h00, acc_b});
      err_reset++;
    end
    if (cc_reg !== `CC_RESET) begin
      report_mismatch("cc_reg", {8'h00, `CC_RESET}, {8'h00, cc_reg});
      err_reset++;
    end
  endtask

  // ----------------------------------------------------------
  // Memory image and program generator
  // ----------------------------------------------------------
  task automatic emit_byte(input logic [7:0] b);
    mem[gen_pc] = b;
    gen_pc      = gen_pc + 16'd1;
  endtask

  task automatic fill_memory();
    int a;
    for (a = 0; a < 65536; a++) begin
      // Background mixes both address bytes
      mem[a[15:0]] = a[15:8] ^ a[7:0] ^ 8'hA5;
    end
    mem[`RESET_VECTOR]          = LOAD_ADDR[15:8];
    mem[`RESET_VECTOR + 16'd1]  = LOAD_ADDR[7:0];
  endtask

  task automatic build_program();
    int unsigned kind;
    int unsigned pick;
    int unsigned rnd;
    int          off;
    int          n;
    int          k;
    gen_pc = LOAD_ADDR;
    for (n = 0; n < NUM_INSTR; n++) begin
      kind = $urandom % 8;
      pick = $urandom;
      rnd  = $urandom;
      if (kind < 2) begin
        // Inherent on A or B
        emit_byte({(rnd[0] ? `ROW_INH_B : `ROW_INH_A), INH_COLS[(pick % 11) * 4 +: 4]});
      end else if (kind < 5) begin
        emit_byte({(rnd[0] ? `ROW_IMM_B : `ROW_IMM_A), IMM_COLS[(pick % 10) * 4 +: 4]});
        emit_byte(rnd[15:8]);
      end else if (kind == 5) begin
        emit_byte(`OP_NOP);
      end else begin
        // Forward branch, skipped bytes padded with NOPs
        off = int'(rnd[15:8] % 8'd7);
        emit_byte({`ROW_BRANCH, pick[3:0]});
        emit_byte(off[7:0]);
        for (k = 0; k < off; k++) begin
          emit_byte(`OP_NOP);
        end
      end
    end
    loop_addr = gen_pc;
    emit_byte(8'h20);
    emit_byte(8'hFE);
    prog_bytes = int'(gen_pc - LOAD_ADDR);
  endtask

  // ----------------------------------------------------------
  // Reference model, data-sheet flag rules
  // ----------------------------------------------------------
  task automatic exec_inherent(input logic [3:0] col, input logic [7:0] v,
                               output logic [7:0] r, output logic wr);
    logic c_old;
    c_old = m_cc[`CC_C];
    wr    = 1'b1;
    r     = v;
    case (col)
      4'h0: begin
        r = 8'h00 - v;
        m_cc[`CC_V] = (v == 8'h80);
        m_cc[`CC_C] = (v != 8'h00);
      end
      4'h3: begin
        r = ~v;
        m_cc[`CC_V] = 1'b0;
        m_cc[`CC_C] = 1'b1;
      end
      // LSR ROR ASR, V untouched
      4'h4, 4'h6, 4'h7: begin
        r = v >> 1;
        if (col == 4'h6) begin
          r[7] = c_old;
        end
        if (col == 4'h7) begin
          r[7] = v[7];
        end
        m_cc[`CC_C] = v[0];
      end
      4'h8, 4'h9: begin
        r = v << 1;
        if (col == 4'h9) begin
          r[0] = c_old;
        end
        m_cc[`CC_V] = v[7] ^ v[6];
        m_cc[`CC_C] = v[7];
      end
      // DEC and INC keep carry
      4'hA: begin
        r = v - 8'h01;
        m_cc[`CC_V] = (v == 8'h80);
      end
      4'hC: begin
        r = v + 8'h01;
        m_cc[`CC_V] = (v == 8'h7F);
      end
      4'hD: begin
        m_cc[`CC_V] = 1'b0;
        wr = 1'b0;
      end
      4'hF: begin
        r = 8'h00;
        m_cc[`CC_V] = 1'b0;
        m_cc[`CC_C] = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    m_cc[`CC_N] = r[7];
    m_cc[`CC_Z] = (r == 8'h00);
  endtask

  task automatic exec_immediate(input logic [3:0] col, input logic [7:0] v,
                                input logic [7:0] m, output logic [7:0] r,
                                output logic wr);
    int carry;
    int u;
    int s;
    carry = int'(m_cc[`CC_C]);
    wr    = 1'b1;
    r     = v;
    case (col)
      // SUB CMP SBC, C is the borrow
      4'h0, 4'h1, 4'h2: begin
        if (col != 4'h2) begin
          carry = 0;
        end
        u = int'(v) - int'(m) - carry;
        s = int'($signed(v)) - int'($signed(m)) - carry;
        r = u[7:0];
        m_cc[`CC_C] = (u < 0);
        m_cc[`CC_V] = (s < -128) || (s > 127);
        wr = (col != 4'h1);
      end
      4'h4, 4'h5: begin
        r = v & m;
        m_cc[`CC_V] = 1'b0;
        wr = (col == 4'h4);
      end
      4'h6: begin
        r = m;
        m_cc[`CC_V] = 1'b0;
      end
      4'h8: begin
        r = v ^ m;
        m_cc[`CC_V] = 1'b0;
      end
      4'hA: begin
        r = v | m;
        m_cc[`CC_V] = 1'b0;
      end
      // ADC and ADD, only writers of H
      4'h9, 4'hB: begin
        if (col == 4'hB) begin
          carry = 0;
        end
        u = int'(v) + int'(m) + carry;
        s = int'($signed(v)) + int'($signed(m)) + carry;
        r = u[7:0];
        m_cc[`CC_H] = ((int'(v[3:0]) + int'(m[3:0]) + carry) > 15);
        m_cc[`CC_C] = (u > 255);
        m_cc[`CC_V] = (s < -128) || (s > 127);
      end
      default: wr = 1'b0;
    endcase
    m_cc[`CC_N] = r[7];
    m_cc[`CC_Z] = (r == 8'h00);
  endtask

  // BHI BLS BGE BLT BGT BLE and BRN never branch in this subset
  function automatic logic branch_taken(input logic [3:0] col, input logic [7:0] cc);
    case (col)
      4'h0:    return 1'b1;
      4'h4:    return !cc[`CC_C];
      4'h5:    return cc[`CC_C];
      4'h6:    return !cc[`CC_Z];
      4'h7:    return cc[`CC_Z];
      4'h8:    return !cc[`CC_V];
      4'h9:    return cc[`CC_V];
      4'hA:    return !cc[`CC_N];
      4'hB:    return cc[`CC_N];
      default: return 1'b0;
    endcase
  endfunction

  task automatic run_model();
    logic [7:0]  op;
    logic [7:0]  opnd;
    logic [7:0]  acc;
    logic [7:0]  res;
    logic        wr;
    logic        use_b;
    logic [15:0] next_pc;
    m_pc = LOAD_ADDR;
    m_a  = 8'h00;
    m_b  = 8'h00;
    m_cc = `CC_RESET;
    while (m_pc != loop_addr) begin
      op      = mem[m_pc];
      opnd    = mem[m_pc + 16'd1];
      next_pc = m_pc + 16'd1;
      use_b   = (op[7:4] == `ROW_INH_B) || (op[7:4] == `ROW_IMM_B);
      acc     = use_b ? m_b : m_a;
      wr      = 1'b0;
      res     = acc;
      exp_addr.push_back(m_pc);
      if ((op[7:4] == `ROW_INH_A) || (op[7:4] == `ROW_INH_B)) begin
        exec_inherent(op[3:0], acc, res, wr);
      end else if ((op[7:4] == `ROW_IMM_A) || (op[7:4] == `ROW_IMM_B)) begin
        exp_addr.push_back(next_pc);
        next_pc = m_pc + 16'd2;
        exec_immediate(op[3:0], acc, opnd, res, wr);
      end else if (op[7:4] == `ROW_BRANCH) begin
        exp_addr.push_back(next_pc);
        next_pc = m_pc + 16'd2;
        if (branch_taken(op[3:0], m_cc)) begin
          next_pc = next_pc + {{8{opnd[7]}}, opnd};
        end
      end
      if (wr && use_b) begin
        m_b = res;
      end else if (wr) begin
        m_a = res;
      end
      // Visible one cycle after the next opcode read
      chk_cycle.push_back(exp_addr.size() + 1);
      chk_a.push_back(m_a);
      chk_b.push_back(m_b);
      chk_cc.push_back(m_cc);
      m_pc = next_pc;
    end
    // Closing BRA to itself, opcode then offset
    exp_addr.push_back(loop_addr);
    exp_addr.push_back(loop_addr + 16'd1);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    clk          = 1'b0;
    reset_b      = 1'b0;
    gen_done     = 1'b0;
    err_reset    = 0;
    err_vector   = 0;
    err_fetch    = 0;
    err_regs     = 0;
    err_final    = 0;
    tests_passed = 0;
    tests_failed = 0;
    diverged     = 1'b0;
    void'($urandom(SEED));
    fill_memory();
    build_program();
    run_model();
    $display("Program of %0d bytes at 0x%h, %0d fetch cycles expected",
             prog_bytes, LOAD_ADDR, exp_addr.size());
    gen_done = 1'b1;

    for (i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_reset_values();
    end
    @(posedge clk);
    reset_b <= 1'b1;

    // Two vector reads, high byte first
    @(negedge clk);
    check_reset_values();
    @(negedge clk);
    if (addr !== (`RESET_VECTOR + 16'd1)) begin
      report_mismatch("addr", `RESET_VECTOR + 16'd1, addr);
      err_reset++;
    end
    finish_test("reset state", err_reset);

    c       = 0;
    chk_idx = 0;
    while ((c < exp_addr.size()) && !diverged) begin
      @(negedge clk);
      if (c == 0) begin
        if (addr !== LOAD_ADDR) begin
          report_mismatch("addr", LOAD_ADDR, addr);
          err_vector++;
        end
        finish_test("vector load", err_vector);
      end
      if (addr !== exp_addr[c]) begin
        report_mismatch("addr", exp_addr[c], addr);
        $display("Fetch sequence left the model's path at fetch cycle %0d", c);
        err_fetch++;
        diverged = 1'b1;
      end
      if (!diverged && (chk_idx < chk_cycle.size()) && (chk_cycle[chk_idx] == c)) begin
        if (acc_a !== chk_a[chk_idx]) begin
          report_mismatch("acc_a", {8'h00, chk_a[chk_idx]}, {8'h00, acc_a});
          err_regs++;
        end
        if (acc_b !== chk_b[chk_idx]) begin
          report_mismatch("acc_b", {8'h00, chk_b[chk_idx]}, {8'h00, acc_b});
          err_regs++;
        end
        if (cc_reg !== chk_cc[chk_idx]) begin
          report_mismatch("cc_reg", {8'h00, chk_cc[chk_idx]}, {8'h00, cc_reg});
          err_regs++;
        end
        chk_idx++;
      end
      c++;
    end
    finish_test("fetch address sequence", err_fetch);
    finish_test("register results", err_regs);

    // Back at the loop opcode, state must be final
    if (diverged) begin
      $display("Final state was not checked because the fetch sequence diverged");
      err_final++;
    end else begin
      @(negedge clk);
      if (addr !== loop_addr) begin
        report_mismatch("addr", loop_addr, addr);
        err_final++;
      end
      if (acc_a !== m_a) begin
        report_mismatch("acc_a", {8'h00, m_a}, {8'h00, acc_a});
        err_final++;
      end
      if (acc_b !== m_b) begin
        report_mismatch("acc_b", {8'h00, m_b}, {8'h00, acc_b});
        err_final++;
      end
      if (cc_reg !== m_cc) begin
        report_mismatch("cc_reg", {8'h00, m_cc}, {8'h00, cc_reg});
        err_final++;
      end
    end
    finish_test("final state", err_final);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog, four times the program length plus margin
  initial begin
    wait (gen_done);
    #((prog_bytes + 50) * 40);
    $display("Timeout: the core did not reach the final loop within %0d ns",
             (prog_bytes + 50) * 40);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/cpu6809_top.sv
// ----------------------------------------------------------
// Top level of the 8-bit accumulator core
// Fetch sequencer, execute unit and program counter
// joined to a read-only byte bus
// A, B and CC brought out as a register view
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cpu6809_top import cpu6809_pkg::*; (
  input  logic  clk,
  input  logic  reset_b,
  // Read data, valid in the same cycle as addr
  input  byte_t din,
  output addr_t addr,
  // Register view for a debug monitor
  output byte_t acc_a,
  output byte_t acc_b,
  output cc_t   cc_reg
);

  // ----------------------------------------------------------
  // Internal connections
  // ----------------------------------------------------------
  // Reset-vector progress, also selects the address source
  vector_state_t vec_phase;
  // Instruction captured in its fetch cycle
  byte_t         opcode;
  // Vector high byte, later the immediate or offset byte
  byte_t         post_byte;
  // Offset or immediate byte on din this cycle
  logic          operand_strobe;
  // Write-back pulse, one cycle after an ALU instruction
  logic          exec_strobe;

  // Opcode and post-byte capture, fetch FSM
  fetch_sequencer u_fetch (
    .clk            (clk),
    .reset_b        (reset_b),
    .din            (din),
    .vec_phase      (vec_phase),
    .opcode         (opcode),
    .operand_strobe (operand_strobe),
    .exec_strobe    (exec_strobe),
    .vector_hi      (post_byte)
  );

  // Accumulators, CC and the ALU
  exec_unit u_exec (
    .clk         (clk),
    .reset_b     (reset_b),
    .opcode      (opcode),
    .operand     (post_byte),
    .exec_strobe (exec_strobe),
    .acc_a       (acc_a),
    .acc_b       (acc_b),
    .cc_reg      (cc_reg)
  );

  // Program counter, branch decision and bus address
  pc_branch u_pc (
    .clk            (clk),
    .reset_b        (reset_b),
    .din            (din),
    .vec_phase      (vec_phase),
    .vector_hi      (post_byte),
    .opcode         (opcode),
    .operand_strobe (operand_strobe),
    .cc_reg         (cc_reg),
    .addr           (addr)
  );

endmodule

`default_nettype wire

//--- src/pc_branch.sv
// ----------------------------------------------------------
// Program counter and short-branch control
// Vector address counter for the two reset reads
// Branch condition test on the captured opcode column
// Bus address mux
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "cpu6809_cfg.svh"

module pc_branch import cpu6809_pkg::*; (
  input  logic          clk,
  input  logic          reset_b,
  input  byte_t         din,
  input  vector_state_t vec_phase,
  input  byte_t         vector_hi,
  input  byte_t         opcode,
  input  logic          operand_strobe,
  input  cc_t           cc_reg,
  output addr_t         addr
);

  // Address of the byte read this cycle
  addr_t   pc_q;
  addr_t   vec_addr_q;
  addr_t   pc_inc;
  addr_t   offset;
  nibble_t br_col;
  logic    branch_row;
  logic    cond_true;
  logic    branch_taken;
  logic    fetching;

  assign fetching   = (vec_phase == VEC_DONE);
  assign branch_row = (opcode[7:4] == `ROW_BRANCH);
  assign br_col     = opcode[3:0];
  assign pc_inc     = pc_q + 16'h0001;
  // Offset byte is on din during the operand cycle
  assign offset     = {{8{din[7]}}, din};

  // ----------------------------------------------------------
  // Branch conditions by column
  // ----------------------------------------------------------
  always_comb begin
    case (br_col)
      4'h0:    cond_true = 1'b1;
      4'h4:    cond_true = !cc_reg[`CC_C];
      4'h5:    cond_true = cc_reg[`CC_C];
      4'h6:    cond_true = !cc_reg[`CC_Z];
      4'h7:    cond_true = cc_reg[`CC_Z];
      4'h8:    cond_true = !cc_reg[`CC_V];
      4'h9:    cond_true = cc_reg[`CC_V];
      4'hA:    cond_true = !cc_reg[`CC_N];
      4'hB:    cond_true = cc_reg[`CC_N];
      // BRN, plus BHI BLS BGE BLT BGT BLE never taken here
      default: cond_true = 1'b0;
    endcase
  end

  assign branch_taken = operand_strobe && branch_row && cond_true;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      pc_q       <= 16'h0000;
      vec_addr_q <= `RESET_VECTOR;
    end else begin
      // High vector byte done, step to the low byte
      if (vec_phase == VEC_HI) begin
        vec_addr_q <= vec_addr_q + 16'h0001;
      end
      if (vec_phase == VEC_LO) begin
        pc_q <= {vector_hi, din};
      end else if (branch_taken) begin
        // Target relative to the byte after the offset
        pc_q <= pc_inc + offset;
      end else if (fetching) begin
        pc_q <= pc_inc;
      end
    end
  end

  assign addr = fetching ? pc_q : vec_addr_q;

endmodule

`default_nettype wire

//--- src/exec_unit.sv
// ----------------------------------------------------------
// Execute unit
// A, B and CC registers
// Accumulator and operand select by opcode row
// Result write-back and CC merge on the write-back strobe
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "cpu6809_cfg.svh"

module exec_unit import cpu6809_pkg::*; (
  input  logic  clk,
  input  logic  reset_b,
  input  byte_t opcode,
  input  byte_t operand,
  input  logic  exec_strobe,
  output byte_t acc_a,
  output byte_t acc_b,
  output cc_t   cc_reg
);

  byte_t   a_q;
  byte_t   b_q;
  cc_t     cc_q;
  nibble_t row;
  nibble_t col;
  logic    imm_row;
  logic    sel_b;
  byte_t   alu_lhs;
  byte_t   alu_rhs;
  byte_t   alu_result;
  cc_t     alu_flags;
  // CMP, BIT and TST only touch CC
  logic    no_write;
  // Half carry comes from ADD and ADC only
  logic    h_write;
  // Right shifts leave V alone
  logic    v_keep;
  cc_t     cc_next;

  assign row = opcode[7:4];
  assign col = opcode[3:0];

  assign imm_row = (row == `ROW_IMM_A) || (row == `ROW_IMM_B);
  assign sel_b   = (row == `ROW_INH_B) || (row == `ROW_IMM_B);

  // Inherent forms see zero on the right-hand side
  assign alu_lhs = sel_b ? b_q : a_q;
  assign alu_rhs = imm_row ? operand : 8'h00;

  alu8 u_alu8 (
    .lhs           (alu_lhs),
    .rhs           (alu_rhs),
    .op            (col),
    .immediate_row (imm_row),
    .c_in          (cc_q[`CC_C]),
    .result        (alu_result),
    .flags         (alu_flags)
  );

  assign no_write = imm_row ? ((col == 4'h1) || (col == 4'h5)) : (col == 4'hD);
  assign h_write  = imm_row && ((col == 4'h9) || (col == 4'hB));
  assign v_keep   = !imm_row && ((col == 4'h4) || (col == 4'h6) || (col == 4'h7));

  // ----------------------------------------------------------
  // CC merge, interrupt masks and E untouched
  // ----------------------------------------------------------
  always_comb begin
    cc_next         = cc_q;
    cc_next[`CC_N]  = alu_flags[`CC_N];
    cc_next[`CC_Z]  = alu_flags[`CC_Z];
    cc_next[`CC_C]  = alu_flags[`CC_C];
    if (!v_keep) begin
      cc_next[`CC_V] = alu_flags[`CC_V];
    end
    if (h_write) begin
      cc_next[`CC_H] = alu_flags[`CC_H];
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_q  <= 8'h00;
      b_q  <= 8'h00;
      cc_q <= `CC_RESET;
    end else if (exec_strobe) begin
      cc_q <= cc_next;
      if (!no_write) begin
        if (sel_b) begin
          b_q <= alu_result;
        end else begin
          a_q <= alu_result;
        end
      end
    end
  end

  assign acc_a  = a_q;
  assign acc_b  = b_q;
  assign cc_reg = cc_q;

endmodule

`default_nettype wire

//--- src/fetch_sequencer.sv
// ----------------------------------------------------------
// Fetch sequencer
// Two-cycle reset-vector load
// Opcode classification by row into one- or two-byte forms
// Opcode and post-byte registers, write-back strobe
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "cpu6809_cfg.svh"

module fetch_sequencer import cpu6809_pkg::*; (
  input  logic          clk,
  input  logic          reset_b,
  input  byte_t         din,
  output vector_state_t vec_phase,
  output byte_t         opcode,
  output logic          operand_strobe,
  output logic          exec_strobe,
  output byte_t         vector_hi
);

  vector_state_t vec_state;
  fetch_state_t  fetch_state;
  byte_t         opcode_q;
  // Shared by the vector high byte and the instruction post-byte
  byte_t         post_byte_q;
  logic          exec_q;

  // Row of the byte on the bus, meaningful in FETCH_OPCODE
  nibble_t din_row;
  // Row of the instruction already captured
  nibble_t op_row;
  logic    fetching;
  logic    din_two_byte;
  logic    din_inh_alu;
  logic    op_imm_alu;

  assign din_row  = din[7:4];
  assign op_row   = opcode_q[7:4];
  assign fetching = (vec_state == VEC_DONE);

  // Branch and immediate rows carry one more byte
  assign din_two_byte = (din_row == `ROW_BRANCH) ||
                        (din_row == `ROW_IMM_A)  ||
                        (din_row == `ROW_IMM_B);

  // Inherent ALU rows finish in their opcode cycle
  assign din_inh_alu = (din_row == `ROW_INH_A) || (din_row == `ROW_INH_B);

  // Immediate ALU rows finish in their operand cycle
  assign op_imm_alu = (op_row == `ROW_IMM_A) || (op_row == `ROW_IMM_B);

  // ----------------------------------------------------------
  // Vector load and fetch FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      vec_state   <= VEC_HI;
      fetch_state <= FETCH_OPCODE;
      exec_q      <= 1'b0;
    end else begin
      exec_q <= 1'b0;
      case (vec_state)
        VEC_HI:  vec_state <= VEC_LO;
        VEC_LO:  vec_state <= VEC_DONE;
        default: vec_state <= VEC_DONE;
      endcase
      if (fetching) begin
        case (fetch_state)
          FETCH_OPCODE: begin
            if (din_two_byte) begin
              fetch_state <= FETCH_OPERAND;
            end
            exec_q <= din_inh_alu;
          end
          default: begin
            // Post-byte read, back to opcode fetch
            fetch_state <= FETCH_OPCODE;
            exec_q      <= op_imm_alu;
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------
  // Instruction and post-byte capture
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (fetching && (fetch_state == FETCH_OPCODE)) begin
      opcode_q <= din;
    end
    // Vector high byte first, then each immediate or offset
    if ((vec_state == VEC_HI) || operand_strobe) begin
      post_byte_q <= din;
    end
  end

  assign operand_strobe = fetching && (fetch_state == FETCH_OPERAND);
  assign vec_phase      = vec_state;
  assign opcode         = opcode_q;
  assign vector_hi      = post_byte_q;
  assign exec_strobe    = exec_q;

endmodule

`default_nettype wire

//--- src/alu8.sv
// ----------------------------------------------------------
// 8-bit ALU in 6809 column encoding
// Inherent row, NEG COM LSR ROR ASR ASL ROL DEC INC TST CLR
// Immediate row, SUB CMP SBC AND BIT LD EOR ADC OR ADD
// Result plus N, Z, V, C and H
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "cpu6809_cfg.svh"

module alu8 import cpu6809_pkg::*; (
  input  byte_t   lhs,
  input  byte_t   rhs,
  input  nibble_t op,
  input  logic    immediate_row,
  input  logic    c_in,
  output byte_t   result,
  output cc_t     flags
);

  // Carry into ADC, borrow into SBC
  logic       add_cin;
  logic       sub_bin;
  logic [8:0] add_sum;
  logic [8:0] sub_diff;
  logic       add_v;
  logic       sub_v;
  logic       add_h;
  byte_t      res;
  logic       v_flag;
  logic       c_flag;

  assign add_cin  = (op == 4'h9) && c_in;
  assign sub_bin  = (op == 4'h2) && c_in;
  assign add_sum  = {1'b0, lhs} + {1'b0, rhs} + {8'h00, add_cin};
  assign sub_diff = {1'b0, lhs} - {1'b0, rhs} - {8'h00, sub_bin};

  // Signed overflow of the adder and subtractor
  assign add_v = (lhs[7] == rhs[7]) && (add_sum[7] != lhs[7]);
  assign sub_v = (lhs[7] != rhs[7]) && (sub_diff[7] != lhs[7]);

  // Carry out of bit 3
  assign add_h = (lhs[3] & rhs[3]) | (rhs[3] & ~add_sum[3]) | (~add_sum[3] & lhs[3]);

  // ----------------------------------------------------------
  // Column decode
  // ----------------------------------------------------------
  always_comb begin
    // Carry passes through unless the operation defines it
    res    = lhs;
    v_flag = 1'b0;
    c_flag = c_in;
    if (immediate_row) begin
      case (op)
        // SUB, CMP, SBC
        4'h0, 4'h1, 4'h2: begin
          res    = sub_diff[7:0];
          v_flag = sub_v;
          c_flag = sub_diff[8];
        end
        // AND and BIT
        4'h4, 4'h5: res = lhs & rhs;
        // LD
        4'h6: res = rhs;
        4'h8: res = lhs ^ rhs;
        4'hA: res = lhs | rhs;
        // ADC and ADD
        4'h9, 4'hB: begin
          res    = add_sum[7:0];
          v_flag = add_v;
          c_flag = add_sum[8];
        end
        default: res = lhs;
      endcase
    end else begin
      case (op)
        // NEG, borrow whenever the operand is nonzero
        4'h0: begin
          res    = 8'h00 - lhs;
          v_flag = (lhs == 8'h80);
          c_flag = (lhs != 8'h00);
        end
        // COM always sets carry
        4'h3: begin
          res    = ~lhs;
          c_flag = 1'b1;
        end
        // LSR, ROR, ASR shift bit 0 into carry
        4'h4: begin
          res    = {1'b0, lhs[7:1]};
          c_flag = lhs[0];
        end
        4'h6: begin
          res    = {c_in, lhs[7:1]};
          c_flag = lhs[0];
        end
        4'h7: begin
          res    = {lhs[7], lhs[7:1]};
          c_flag = lhs[0];
        end
        // ASL and ROL, V is bit 7 xor bit 6
        4'h8, 4'h9: begin
          res    = {lhs[6:0], (op == 4'h9) && c_in};
          v_flag = lhs[7] ^ lhs[6];
          c_flag = lhs[7];
        end
        4'hA: begin
          res    = lhs - 8'h01;
          v_flag = (lhs == 8'h80);
        end
        4'hC: begin
          res    = lhs + 8'h01;
          v_flag = (lhs == 8'h7F);
        end
        // CLR
        4'hF: begin
          res    = 8'h00;
          c_flag = 1'b0;
        end
        // TST and unused columns
        default: res = lhs;
      endcase
    end
  end

  // Only the five arithmetic flags are driven
  always_comb begin
    flags         = '0;
    flags[`CC_N]  = res[7];
    flags[`CC_Z]  = (res == 8'h00);
    flags[`CC_V]  = v_flag;
    flags[`CC_C]  = c_flag;
    flags[`CC_H]  = add_h;
  end

  assign result = res;

endmodule

`default_nettype wire

//--- src/cpu6809_pkg.sv
// ----------------------------------------------------------
// Shared types for the accumulator core
// Data, address, nibble and condition-code vectors
// Reset-vector and fetch state encodings
// ----------------------------------------------------------
`default_nettype none

package cpu6809_pkg;

  // Data bus and register value
  typedef logic [7:0] byte_t;

  // Memory address, big-endian in memory
  typedef logic [15:0] addr_t;

  // Opcode row or column
  typedef logic [3:0] nibble_t;

  // Condition codes, E F H I N Z V C from bit 7 down
  typedef logic [7:0] cc_t;

  // Reset-vector load, two reads then normal fetch
  typedef enum logic [1:0] {
    VEC_HI,
    VEC_LO,
    VEC_DONE
  } vector_state_t;

  // Instruction fetch, opcode byte or its post-byte
  typedef enum logic {
    FETCH_OPCODE,
    FETCH_OPERAND
  } fetch_state_t;

endpackage

`default_nettype wire

//--- src/cpu6809_cfg.svh
// ----------------------------------------------------------
// Configuration constants for the 8-bit accumulator core
// Reset vector address and CC reset value
// Condition-code bit positions
// Opcode row codes used by the row and column decode
// ----------------------------------------------------------
`ifndef CPU6809_CFG_SVH
`define CPU6809_CFG_SVH

// First of the two vector bytes, high byte first
`define RESET_VECTOR 16'hFFFE

// E, F and I set out of reset
`define CC_RESET 8'hD0

// ----------------------------------------------------------
// Condition-code bit positions
// ----------------------------------------------------------
// Entire state saved
`define CC_E 7
// FIRQ mask
`define CC_F 6
// Half carry from bit 3
`define CC_H 5
// IRQ mask
`define CC_I 4
`define CC_N 3
`define CC_Z 2
`define CC_V 1
`define CC_C 0

// ----------------------------------------------------------
// Opcode rows (upper nibble)
// ----------------------------------------------------------
// Inherent accumulator operations
`define ROW_INH_A 4'h4
`define ROW_INH_B 4'h5
// 8-bit immediate operations
`define ROW_IMM_A 4'h8
`define ROW_IMM_B 4'hC
// Short relative branches
`define ROW_BRANCH 4'h2

`define OP_NOP 8'h12

`endif
